//--- hdl/mm_ram_defines.svh
// memory map and width macros
`ifndef MM_RAM_DEFINES_SVH
`define MM_RAM_DEFINES_SVH

`default_nettype none

// byte address width of the ram, 16 KiB
`define RAM_ADDR_WIDTH 14
// one instruction line is four words
`define INSTR_RDATA_WIDTH 128

// peripheral word addresses
`define STATUS_ADDR 32'h2000_0004
`define EXIT_ADDR 32'h2000_0010
`define TIMER_ADDR 32'h1500_0000

// codes written to the status address
`define TEST_PASS_CODE 32'd123456789
`define TEST_FAIL_CODE 32'd1

// timer command fields
`define IRQ_ID_WIDTH 5
`define TIMER_CNT_WIDTH 27

`default_nettype wire

`endif

//--- hdl/mem_map_pkg.sv
// address map types
`include "mm_ram_defines.svh"
`default_nettype none

package mem_map_pkg;

    // decoded target of a data access
    typedef enum logic [2:0] {
        REGION_RAM    = 3'd0,
        REGION_STATUS = 3'd1,
        REGION_EXIT   = 3'd2,
        REGION_TIMER  = 3'd3,
        REGION_NONE   = 3'd4
    } mem_region_e;

    // word index into the ram
    typedef logic [`RAM_ADDR_WIDTH-3:0] ram_word_addr_t;

    // line index, four words per line
    typedef logic [`RAM_ADDR_WIDTH-5:0] ram_line_addr_t;

    // word offset inside a line
    typedef logic [1:0] ram_line_ofs_t;

endpackage

`default_nettype wire

//--- hdl/periph_pkg.sv
// peripheral register types
`include "mm_ram_defines.svh"
`default_nettype none

package periph_pkg;

    // interrupt id as seen by the core
    typedef logic [`IRQ_ID_WIDTH-1:0] irq_id_t;

    // countdown value of the timer
    typedef logic [`TIMER_CNT_WIDTH-1:0] timer_cnt_t;

    // timer command word, id in the top bits
    typedef struct packed {
        irq_id_t    irq_id;
        timer_cnt_t count;
    } timer_cmd_t;

    // one mmio write word, decoded per target
    // status and exit take the raw word, timer takes a command
    typedef union packed {
        logic [31:0] raw;
        timer_cmd_t  timer;
    } mmio_wdata_u;

endpackage

`default_nettype wire

//--- hdl/mm_ram_ctrl.sv
// ram and peripheral access control
`include "mm_ram_defines.svh"
`default_nettype none

module mm_ram_ctrl (
    input  wire logic        clk_i,
    input  wire logic        rst_i,

    // instruction port handshake
    input  wire logic        instr_req_i,
    output logic             instr_gnt_o,
    output logic             instr_rvalid_o,

    // data port handshake and address
    input  wire logic        data_req_i,
    input  wire logic        data_we_i,
    input  wire logic [31:0] data_addr_i,
    output logic             data_gnt_o,
    output logic             data_rvalid_o,
    output logic [31:0]      data_rdata_o,

    // ram read word, one cycle after the request
    input  wire logic [31:0] ram_rdata_i,

    // per target write strobes
    output logic             ram_we_o,
    output logic             status_we_o,
    output logic             exit_we_o,
    output logic             timer_we_o
);

    import mem_map_pkg::*;

    mem_region_e region;
    mem_region_e rd_region_q;
    logic        instr_rvalid_q;
    logic        data_rvalid_q;
    logic        data_wr;

    // no back-pressure, a request is granted in its own cycle
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    // address decode, peripherals match on the word address
    always_comb begin
        if (data_addr_i[31:`RAM_ADDR_WIDTH] == '0) begin
            region = REGION_RAM;
        end else if (data_addr_i[31:2] == `STATUS_ADDR >> 2) begin
            region = REGION_STATUS;
        end else if (data_addr_i[31:2] == `EXIT_ADDR >> 2) begin
            region = REGION_EXIT;
        end else if (data_addr_i[31:2] == `TIMER_ADDR >> 2) begin
            region = REGION_TIMER;
        end else begin
            region = REGION_NONE;
        end
    end

    assign data_wr = data_req_i & data_we_i;

    // writes to REGION_NONE raise no strobe and are dropped
    assign ram_we_o    = data_wr & (region == REGION_RAM);
    assign status_we_o = data_wr & (region == REGION_STATUS);
    assign exit_we_o   = data_wr & (region == REGION_EXIT);
    assign timer_we_o  = data_wr & (region == REGION_TIMER);

    // response pipeline, one stage for each port
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
            rd_region_q    <= REGION_NONE;
        end else begin
            instr_rvalid_q <= instr_req_i;
            data_rvalid_q  <= data_req_i;
            // only a read keeps its region, write responses carry zero
            if (data_req_i && !data_we_i) begin
                rd_region_q <= region;
            end else begin
                rd_region_q <= REGION_NONE;
            end
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;
    assign data_rvalid_o  = data_rvalid_q;

    // ram word on a ram read, zero for everything else
    assign data_rdata_o = (data_rvalid_q && rd_region_q == REGION_RAM) ? ram_rdata_i : '0;

endmodule

`default_nettype wire

//--- hdl/dp_ram.sv
// dual port word ram
`include "mm_ram_defines.svh"
`default_nettype none

module dp_ram (
    input  wire logic                          clk_i,

    // instruction port, one line per read
    input  wire mem_map_pkg::ram_word_addr_t   instr_addr_i,
    output logic [`INSTR_RDATA_WIDTH-1:0]      instr_rdata_o,

    // data port with byte enables
    input  wire mem_map_pkg::ram_word_addr_t   data_addr_i,
    input  wire logic                          data_we_i,
    input  wire logic [3:0]                    data_be_i,
    input  wire logic [31:0]                   data_wdata_i,
    output logic [31:0]                        data_rdata_o
);

    import mem_map_pkg::*;

    // four bytes per word
    logic [3:0][7:0] mem [0:2**(`RAM_ADDR_WIDTH-2)-1];

    logic [`INSTR_RDATA_WIDTH-1:0] instr_rdata_q;
    logic [31:0]                   data_rdata_q;
    ram_line_addr_t                instr_line;

    // drop the word offset, lines are 16 byte aligned
    assign instr_line = instr_addr_i[$bits(ram_word_addr_t)-1:2];

    // data port, read returns the word before a same-cycle write
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (data_we_i && data_be_i[b]) begin
                mem[data_addr_i][b] <= data_wdata_i[b*8 +: 8];
            end
        end
        data_rdata_q <= mem[data_addr_i];
    end

    // instruction port, lowest address in the low word
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `INSTR_RDATA_WIDTH/32; w++) begin
            instr_rdata_q[w*32 +: 32] <= mem[{instr_line, ram_line_ofs_t'(w)}];
        end
    end

    assign instr_rdata_o = instr_rdata_q;
    assign data_rdata_o  = data_rdata_q;

endmodule

`default_nettype wire

//--- hdl/vp_status.sv
// test status and exit peripheral
`include "mm_ram_defines.svh"
`default_nettype none

module vp_status (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     status_we_i,
    input  wire logic                     exit_we_i,
    input  wire periph_pkg::mmio_wdata_u  wdata_i,
    output logic                          tests_passed_o,
    output logic                          tests_failed_o,
    output logic                          exit_valid_o,
    output logic [31:0]                   exit_value_o
);

    logic        passed_q;
    logic        failed_q;
    logic        exit_valid_q;
    logic [31:0] exit_value_q;

    // sticky flags, any other code is ignored
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
            exit_valid_q <= 1'b0;
        end else begin
            if (status_we_i && wdata_i.raw == `TEST_PASS_CODE) begin
                passed_q <= 1'b1;
            end
            if (status_we_i && wdata_i.raw == `TEST_FAIL_CODE) begin
                failed_q <= 1'b1;
            end
            // one pulse per exit write
            exit_valid_q <= exit_we_i;
        end
    end

    // exit value stays until the next exit write
    always_ff @(posedge clk_i) begin
        if (exit_we_i) begin
            exit_value_q <= wdata_i.raw;
        end
    end

    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;

endmodule

`default_nettype wire

//--- hdl/vp_timer_irq.sv
// timer interrupt peripheral
`include "mm_ram_defines.svh"
`default_nettype none

module vp_timer_irq (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     timer_we_i,
    input  wire periph_pkg::mmio_wdata_u  wdata_i,
    input  wire logic                     irq_ack_i,
    input  wire periph_pkg::irq_id_t      irq_id_i,
    output logic                          irq_o,
    output periph_pkg::irq_id_t           irq_id_o
);

    import periph_pkg::*;

    timer_cmd_t cmd;
    timer_cnt_t count_q;
    irq_id_t    load_id_q;
    irq_id_t    pend_id_q;
    logic       armed_q;
    logic       irq_q;

    // the written word read as a command
    assign cmd = wdata_i.timer;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            armed_q   <= 1'b0;
            irq_q     <= 1'b0;
            pend_id_q <= '0;
        end else begin
            // ack must carry the pending id
            if (irq_q && irq_ack_i && irq_id_i == pend_id_q) begin
                irq_q <= 1'b0;
            end
            // expiry, irq shows count+1 cycles after the write
            if (armed_q) begin
                if (count_q == timer_cnt_t'(1)) begin
                    armed_q   <= 1'b0;
                    irq_q     <= 1'b1;
                    pend_id_q <= load_id_q;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
            // a new command overrides the countdown
            if (timer_we_i) begin
                count_q   <= cmd.count;
                load_id_q <= cmd.irq_id;
                armed_q   <= (cmd.count != '0);
                // zero count disarms and drops a pending irq
                if (cmd.count == '0) begin
                    irq_q <= 1'b0;
                end
            end
        end
    end

    assign irq_o    = irq_q;
    assign irq_id_o = pend_id_q;

endmodule

`default_nettype wire

//--- hdl/mm_ram.sv
// memory-mapped ram with virtual peripherals
`include "mm_ram_defines.svh"
`default_nettype none

module mm_ram (
    input  wire logic                         clk_i,
    input  wire logic                         rst_i,

    // instruction port, read only
    input  wire logic                         instr_req_i,
    input  wire logic [`RAM_ADDR_WIDTH-1:0]   instr_addr_i,
    output logic                              instr_gnt_o,
    output logic                              instr_rvalid_o,
    output logic [`INSTR_RDATA_WIDTH-1:0]     instr_rdata_o,

    // data port
    input  wire logic                         data_req_i,
    input  wire logic [31:0]                  data_addr_i,
    input  wire logic                         data_we_i,
    input  wire logic [3:0]                   data_be_i,
    input  wire logic [31:0]                  data_wdata_i,
    output logic                              data_gnt_o,
    output logic                              data_rvalid_o,
    output logic [31:0]                       data_rdata_o,

    // interrupt to and ack from the core
    input  wire logic                         irq_ack_i,
    input  wire periph_pkg::irq_id_t          irq_id_i,
    output logic                              irq_o,
    output periph_pkg::irq_id_t               irq_id_o,

    // test status
    output logic                              tests_passed_o,
    output logic                              tests_failed_o,
    output logic                              exit_valid_o,
    output logic [31:0]                       exit_value_o
);

    logic        ram_we;
    logic        status_we;
    logic        exit_we;
    logic        timer_we;
    logic [31:0] ram_rdata;

    // decode, strobes and response timing
    mm_ram_ctrl ctrl0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_req_i    (instr_req_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .data_req_i     (data_req_i),
        .data_we_i      (data_we_i),
        .data_addr_i    (data_addr_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .ram_rdata_i    (ram_rdata),
        .ram_we_o       (ram_we),
        .status_we_o    (status_we),
        .exit_we_o      (exit_we),
        .timer_we_o     (timer_we)
    );

    // ram sees word addresses, byte offset dropped
    dp_ram ram0 (
        .clk_i         (clk_i),
        .instr_addr_i  (instr_addr_i[`RAM_ADDR_WIDTH-1:2]),
        .instr_rdata_o (instr_rdata_o),
        .data_addr_i   (data_addr_i[`RAM_ADDR_WIDTH-1:2]),
        .data_we_i     (ram_we),
        .data_be_i     (data_be_i),
        .data_wdata_i  (data_wdata_i),
        .data_rdata_o  (ram_rdata)
    );

    vp_status status0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .status_we_i    (status_we),
        .exit_we_i      (exit_we),
        .wdata_i        (data_wdata_i),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    vp_timer_irq timer0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .timer_we_i (timer_we),
        .wdata_i    (data_wdata_i),
        .irq_ack_i  (irq_ack_i),
        .irq_id_i   (irq_id_i),
        .irq_o      (irq_o),
        .irq_id_o   (irq_id_o)
    );

endmodule

`default_nettype wire

//--- tb/mm_ram_sva.sv
// mm_ram protocol assertions
`default_nettype none

module mm_ram_sva (
    input wire logic                clk_i,
    input wire logic                rst_i,
    input wire logic                instr_req_i,
    input wire logic                instr_gnt_o,
    input wire logic                instr_rvalid_o,
    input wire logic                data_req_i,
    input wire logic                data_gnt_o,
    input wire logic                data_rvalid_o,
    input wire logic                exit_valid_o,
    input wire logic                irq_ack_i,
    input wire periph_pkg::irq_id_t irq_id_i,
    input wire logic                irq_o,
    input wire periph_pkg::irq_id_t irq_id_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions
    int unsigned fail_count = 0;

    // grants are combinational, never withheld
    instr_gnt_a: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_gnt_o == instr_req_i) else begin
        fail_count++;
        $error("instr grant does not match instr request");
    end

    data_gnt_a: assert property (@(posedge clk_i) disable iff (rst_i)
        data_gnt_o == data_req_i) else begin
        fail_count++;
        $error("data grant does not match data request");
    end

    // one response per grant, exactly one cycle later
    instr_rvalid_a: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_rvalid_o == $past(instr_gnt_o)) else begin
        fail_count++;
        $error("instr rvalid not one cycle after grant");
    end

    data_rvalid_a: assert property (@(posedge clk_i) disable iff (rst_i)
        data_rvalid_o == $past(data_gnt_o)) else begin
        fail_count++;
        $error("data rvalid not one cycle after grant");
    end

    exit_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
        exit_valid_o |=> !exit_valid_o) else begin
        fail_count++;
        $error("exit valid held longer than one cycle");
    end

    // matching ack drops the irq on the next cycle
    irq_clear_a: assert property (@(posedge clk_i) disable iff (rst_i)
        irq_o && irq_ack_i && irq_id_i == irq_id_o |=> !irq_o) else begin
        fail_count++;
        $error("irq still raised after a matching ack");
    end

endmodule

bind mm_ram mm_ram_sva sva0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_req_i    (instr_req_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .data_req_i     (data_req_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .exit_valid_o   (exit_valid_o),
    .irq_ack_i      (irq_ack_i),
    .irq_id_i       (irq_id_i),
    .irq_o          (irq_o),
    .irq_id_o       (irq_id_o)
);

`default_nettype wire

//--- tb/mm_ram_tb.sv
// mm_ram testbench
`include "mm_ram_defines.svh"
`default_nettype none

module mm_ram_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import periph_pkg::*;

    localparam int MAX_CYCLES = 4000;
    localparam int N_WORDS    = 16;

    logic                          clk;
    logic                          rst;
    logic                          instr_req;
    logic [`RAM_ADDR_WIDTH-1:0]    instr_addr;
    logic                          instr_gnt;
    logic                          instr_rvalid;
    logic [`INSTR_RDATA_WIDTH-1:0] instr_rdata;
    logic                          data_req;
    logic [31:0]                   data_addr;
    logic                          data_we;
    logic [3:0]                    data_be;
    logic [31:0]                   data_wdata;
    logic                          data_gnt;
    logic                          data_rvalid;
    logic [31:0]                   data_rdata;
    logic                          irq_ack;
    irq_id_t                       irq_id;
    logic                          irq;
    irq_id_t                       irq_id_out;
    logic                          passed;
    logic                          failed;
    logic                          exit_valid;
    logic [31:0]                   exit_value;

    // model of the ram contents, word indexed
    logic [31:0] ref_mem [0:2**(`RAM_ADDR_WIDTH-2)-1];
    logic [`RAM_ADDR_WIDTH-3:0] addrs [N_WORDS];
    string cur_test;
    int    errors;
    int    err_base;
    int    tests_run;
    int    cycles;

    mm_ram dut0 (
        .clk_i (clk), .rst_i (rst),
        .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_o (instr_gnt),
        .instr_rvalid_o (instr_rvalid), .instr_rdata_o (instr_rdata),
        .data_req_i (data_req), .data_addr_i (data_addr), .data_we_i (data_we),
        .data_be_i (data_be), .data_wdata_i (data_wdata), .data_gnt_o (data_gnt),
        .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata),
        .irq_ack_i (irq_ack), .irq_id_i (irq_id), .irq_o (irq), .irq_id_o (irq_id_out),
        .tests_passed_o (passed), .tests_failed_o (failed),
        .exit_valid_o (exit_valid), .exit_value_o (exit_value)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit, well above the length of all tests
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp) else begin
            $display("error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("test %s done, %0d errors", cur_test, errors - err_base);
    endtask

    // one data request, returns the response word
    task automatic data_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int lat;
        @(posedge clk);
        #1;
        data_req   = 1'b1;
        data_we    = we;
        data_addr  = addr;
        data_be    = be;
        data_wdata = wdata;
        @(negedge clk);
        check_value("data_gnt", 1, data_gnt);
        @(posedge clk);
        #1;
        data_req = 1'b0;
        data_we  = 1'b0;
        lat = 1;
        @(negedge clk);
        while (!data_rvalid && lat < 8) begin
            @(negedge clk);
            lat++;
        end
        if (!data_rvalid) begin
            $display("%s: no data rvalid for address %0h", cur_test, addr);
            errors++;
        end else begin
            check_value("data_rvalid latency", 1, lat);
        end
        rdata = data_rdata;
        // enabled bytes land in the ram, other regions keep the model
        if (we && addr[31:`RAM_ADDR_WIDTH] == '0) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_mem[addr[`RAM_ADDR_WIDTH-1:2]][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    endtask

    initial begin
        logic [31:0]                rd;
        logic [31:0]                wd;
        logic [`RAM_ADDR_WIDTH-5:0] line;
        timer_cmd_t                 cmd;
        int                         n;
        int                         lat;
        void'($urandom(32'h43b4_cb33));
        rst = 1'b1;
        instr_req = 1'b0;
        instr_addr = '0;
        data_req = 1'b0;
        data_addr = '0;
        data_we = 1'b0;
        data_be = '0;
        data_wdata = '0;
        irq_ack = 1'b0;
        irq_id = '0;
        errors = 0;
        tests_run = 0;
        cycles = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // full word first, then a random byte mix on top
        start_test("ram_byte_enable");
        for (int i = 0; i < N_WORDS; i++) begin
            addrs[i] = ($urandom % 2**(`RAM_ADDR_WIDTH-2));
            data_access(1'b1, {addrs[i], 2'b00}, 4'hf, $urandom, rd);
            data_access(1'b1, {addrs[i], 2'b00}, 4'($urandom), $urandom, rd);
        end
        // reads back to back, each response checked a cycle later
        for (int i = 0; i <= N_WORDS; i++) begin
            @(posedge clk);
            #1;
            data_req  = (i < N_WORDS);
            data_addr = (i < N_WORDS) ? {addrs[i], 2'b00} : '0;
            @(negedge clk);
            if (i > 0) begin
                check_value("rvalid", 1, data_rvalid);
                check_value("rdata", ref_mem[addrs[i-1]], data_rdata);
            end
        end
        finish_test();

        // line fill through data port, then instr and data reads together
        start_test("instr_line");
        for (int l = 0; l < 4; l++) begin
            line = $urandom;
            for (int w = 0; w < 4; w++) begin
                data_access(1'b1, {line, 2'(w), 2'b00}, 4'hf, $urandom, rd);
            end
            @(posedge clk);
            #1;
            instr_req  = 1'b1;
            instr_addr = {line, 4'($urandom)};
            data_req   = 1'b1;
            data_addr  = {addrs[l], 2'b00};
            @(negedge clk);
            check_value("instr_gnt", 1, instr_gnt);
            @(posedge clk);
            #1;
            instr_req = 1'b0;
            data_req  = 1'b0;
            @(negedge clk);
            check_value("instr_rvalid", 1, instr_rvalid);
            check_value("line", {ref_mem[{line, 2'd3}], ref_mem[{line, 2'd2}],
                                 ref_mem[{line, 2'd1}], ref_mem[{line, 2'd0}]}, instr_rdata);
            check_value("data word", ref_mem[addrs[l]], data_rdata);
        end
        finish_test();

        start_test("status_other_code");
        data_access(1'b1, `STATUS_ADDR, 4'hf, 32'h0000_00aa, rd);
        check_value("passed", 0, passed);
        check_value("failed", 0, failed);
        finish_test();

        start_test("status_pass_code");
        check_value("passed before", 0, passed);
        data_access(1'b1, `STATUS_ADDR, 4'hf, `TEST_PASS_CODE, rd);
        check_value("passed", 1, passed);
        check_value("failed", 0, failed);
        finish_test();

        // exit pulse lasts one cycle, the value stays
        start_test("exit_write");
        wd = $urandom;
        data_access(1'b1, `EXIT_ADDR, 4'hf, wd, rd);
        check_value("exit_valid", 1, exit_valid);
        check_value("exit_value", wd, exit_value);
        @(negedge clk);
        check_value("exit_valid after", 0, exit_valid);
        check_value("exit_value after", wd, exit_value);
        finish_test();

        start_test("timer_irq");
        n = 3 + $urandom % 30;
        cmd.irq_id = 1 + $urandom % 31;
        cmd.count = n;
        data_access(1'b1, `TIMER_ADDR, 4'hf, cmd, rd);
        // cycles since the write cycle
        lat = 1;
        while (!irq && lat < n + 20) begin
            @(negedge clk);
            lat++;
        end
        if (!irq) begin
            $display("%s: irq never raised", cur_test);
            errors++;
        end
        check_value("irq latency", n + 1, lat);
        check_value("irq_id", cmd.irq_id, irq_id_out);
        @(posedge clk);
        #1;
        irq_ack = 1'b1;
        irq_id  = cmd.irq_id ^ irq_id_t'(1);
        @(posedge clk);
        #1;
        irq_ack = 1'b0;
        @(negedge clk);
        check_value("irq after wrong ack", 1, irq);
        @(posedge clk);
        #1;
        irq_ack = 1'b1;
        irq_id  = cmd.irq_id;
        @(posedge clk);
        #1;
        irq_ack = 1'b0;
        @(negedge clk);
        check_value("irq after ack", 0, irq);
        finish_test();

        start_test("unmapped");
        data_access(1'b0, `STATUS_ADDR, 4'hf, '0, rd);
        check_value("status read", 0, rd);
        data_access(1'b0, `EXIT_ADDR, 4'hf, '0, rd);
        check_value("exit read", 0, rd);
        data_access(1'b0, `TIMER_ADDR, 4'hf, '0, rd);
        check_value("timer read", 0, rd);
        data_access(1'b0, 32'h3000_0000, 4'hf, '0, rd);
        check_value("unmapped read", 0, rd);
        // low bits alias a known ram word
        data_access(1'b1, 32'h0001_0000 | {addrs[0], 2'b00}, 4'hf, `TEST_FAIL_CODE, rd);
        // a stray exit strobe would pulse in this cycle
        check_value("exit_valid", 0, exit_valid);
        data_access(1'b0, {addrs[0], 2'b00}, 4'hf, '0, rd);
        check_value("ram word", ref_mem[addrs[0]], rd);
        check_value("passed", 1, passed);
        check_value("failed", 0, failed);
        check_value("exit_value", wd, exit_value);
        check_value("irq", 0, irq);
        finish_test();

        $display("tests %0d, check errors %0d, assertion failures %0d",
                 tests_run, errors, dut0.sva0.fail_count);
        if (errors == 0 && dut0.sva0.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mm_ram.f
+incdir+hdl
hdl/mem_map_pkg.sv
hdl/periph_pkg.sv
hdl/mm_ram_ctrl.sv
hdl/dp_ram.sv
hdl/vp_status.sv
hdl/vp_timer_irq.sv
hdl/mm_ram.sv
tb/mm_ram_sva.sv
tb/mm_ram_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mm_ram testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mm_ram_tb -f mm_ram.f -o mm_ram_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# raised error limit so that every failing assertion is counted
./obj_dir/mm_ram_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
